/* Bender.yml */
package:
  name: booth_mul

sources:
  - files:
      - common/mul_pkg.sv
      - rtl/pipe_reg.sv
      - booth/booth_pp_gen.sv
      - csa_tree/csa_6to2.sv
      - csa_tree/csa_9to2.sv
      - csa_tree/wallace_tree.sv
      - rtl/product_stage.sv
      - rtl/booth_mul_top.sv
  - target: test
    files:
      - dv/tb_booth_mul.sv

/* booth/booth_pp_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen (
  input  mul_pkg::mul_req_t  req,
  output mul_pkg::pp_array_t rows
);
  import mul_pkg::*;

  logic [OP_W+2:0]          mier;  // Multiplier with a zero below bit 0
  prod_t                    mand;
  booth_sel_t [NUM_PP-2:0]  sel;
  logic [NUM_PP-2:0]        inc;   // Negation increment per digit

  // Inverting the triplet negates the digit
  function automatic booth_sel_t booth_enc(input logic neg, input logic [2:0] trip);
    case ({3{neg}} ^ trip)
      3'b001, 3'b010: booth_enc = SEL_POS1;
      3'b011:         booth_enc = SEL_POS2;
      3'b100:         booth_enc = SEL_NEG2;
      3'b101, 3'b110: booth_enc = SEL_NEG1;
      default:        booth_enc = SEL_ZERO;
    endcase
  endfunction

  // Inverting the full word keeps the row sign-extended up to bit 63
  function automatic prod_t booth_mux(input booth_sel_t s, input prod_t m);
    case (s)
      SEL_POS1: booth_mux = m;
      SEL_NEG1: booth_mux = ~m;
      SEL_POS2: booth_mux = m << 1;
      SEL_NEG2: booth_mux = ~(m << 1);
      default:  booth_mux = '0;
    endcase
  endfunction

  assign mier = {2'b00, req.b, 1'b0};
  assign mand = {{(PROD_W-OP_W){1'b0}}, req.a};

  genvar j;

  for (j = 0; j < NUM_PP - 1; j++) begin : g_digit
    if (j < NUM_BOOTH) begin : g_live
      assign sel[j] = booth_enc(req.negate, mier[2*j +: 3]);
    end else begin : g_pad
      // Padding triplets 000 and 111 both mean zero
      assign sel[j] = SEL_ZERO;
    end
    assign inc[j] = (sel[j] == SEL_NEG1) || (sel[j] == SEL_NEG2);
  end

  for (j = 0; j < NUM_PP; j++) begin : g_row
    prod_t digit_part;
    prod_t inc_part;

    if (j < NUM_PP - 1) begin : g_dig
      assign digit_part = booth_mux(sel[j], mand) << (2 * j);
    end else begin : g_no_dig
      assign digit_part = '0;  // Top row only takes the last increment
    end

    if (j > 0) begin : g_inc
      assign inc_part = prod_t'(inc[j-1]) << (2 * (j - 1));
    end else begin : g_no_inc
      assign inc_part = '0;
    end

    assign rows[j] = digit_part | inc_part;  // Fields never overlap
  end

endmodule

`default_nettype wire

/* common/mul_pkg.sv */
`default_nettype none

package mul_pkg;

  localparam int OP_W      = 32;
  localparam int PROD_W    = 64;
  localparam int NUM_BOOTH = 17;  // Digits that can be nonzero for a 32-bit multiplier
  localparam int NUM_PP    = 34;
  localparam int CSA_GROUP = 9;
  localparam int L1_GROUPS = (NUM_PP - 1) / CSA_GROUP;  // Full 9:2 groups at level one

  typedef logic [OP_W-1:0]   operand_t;
  typedef logic [PROD_W-1:0] prod_t;

  typedef struct packed {
    logic     negate;
    operand_t a;
    operand_t b;
  } mul_req_t;

  // One-hot Booth digit select
  typedef logic [4:0] booth_sel_t;

  localparam booth_sel_t SEL_ZERO = 5'b0_0001;
  localparam booth_sel_t SEL_NEG1 = 5'b0_0010;
  localparam booth_sel_t SEL_POS1 = 5'b0_0100;
  localparam booth_sel_t SEL_NEG2 = 5'b0_1000;
  localparam booth_sel_t SEL_POS2 = 5'b1_0000;

  typedef prod_t [NUM_PP-1:0] pp_array_t;

  // Carry already shifted to its own weight
  typedef struct packed {
    prod_t sum;
    prod_t carry;
  } sum_carry_t;

  // Returns {carry, sum}
  function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
    return {(x & y) | (y & z) | (x & z), x ^ y ^ z};
  endfunction

  // Returns {cout, carry, sum}
  // cout comes from the first adder only, so it never depends on cin
  function automatic logic [2:0] compress_4to2(input logic [3:0] x, input logic cin);
    logic [1:0] lo;
    logic [1:0] hi;
    lo = full_add(x[0], x[1], x[2]);
    hi = full_add(x[3], lo[0], cin);
    return {lo[1], hi};
  endfunction

endpackage

`default_nettype wire

/* compile.f */
common/mul_pkg.sv
rtl/pipe_reg.sv
booth/booth_pp_gen.sv
csa_tree/csa_6to2.sv
csa_tree/csa_9to2.sv
csa_tree/wallace_tree.sv
rtl/product_stage.sv
rtl/booth_mul_top.sv
dv/tb_booth_mul.sv

/* csa_tree/csa_6to2.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_6to2 (
  input  logic [5:0] in,
  input  logic [2:0] cin,
  output logic [2:0] cout,
  output logic       sum,
  output logic       carry
);
  import mul_pkg::*;

  logic [1:0] fa0;  // {carry, sum}
  logic [1:0] fa1;
  logic [2:0] c42;

  assign fa0 = full_add(in[0], in[1], in[2]);
  assign fa1 = full_add(in[3], in[4], in[5]);

  // Lower two lateral carries go straight to the next column
  assign cout[0] = fa0[1];
  assign cout[1] = fa1[1];

  assign c42 = compress_4to2({cin[1], cin[0], fa1[0], fa0[0]}, cin[2]);

  assign cout[2] = c42[2];
  assign carry   = c42[1];
  assign sum     = c42[0];

endmodule

`default_nettype wire

/* csa_tree/csa_9to2.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_9to2 (
  input  logic [8:0] in,
  input  logic [5:0] cin,
  output logic [5:0] cout,
  output logic       sum,
  output logic       carry
);
  import mul_pkg::*;

  logic [1:0] fa0;
  logic [1:0] fa1;
  logic [1:0] fa2;
  logic [2:0] sums;

  assign fa0 = full_add(in[0], in[1], in[2]);
  assign fa1 = full_add(in[3], in[4], in[5]);
  assign fa2 = full_add(in[6], in[7], in[8]);

  assign sums = {fa2[0], fa1[0], fa0[0]};

  assign cout[0] = fa0[1];
  assign cout[1] = fa1[1];
  assign cout[2] = fa2[1];

  // Three local sums plus three incoming carries fill the 6:2 inputs
  csa_6to2 u_6to2 (
    .in    ({cin[2:0], sums}),
    .cin   (cin[5:3]),
    .cout  (cout[5:3]),
    .sum   (sum),
    .carry (carry)
  );

endmodule

`default_nettype wire

/* csa_tree/wallace_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module wallace_tree (
  input  mul_pkg::pp_array_t  rows,
  output mul_pkg::sum_carry_t result
);
  import mul_pkg::*;

  wire [L1_GROUPS:0][PROD_W-1:0]     l1_sum;
  wire [L1_GROUPS:0][PROD_W-1:0]     l1_carry;
  wire [L1_GROUPS-1:0][PROD_W:0][5:0] l1_lat;
  wire [PROD_W:0][2:0]               l1_lat6;
  wire [CSA_GROUP-1:0][PROD_W-1:0]   l2_in;
  wire [PROD_W:0][5:0]               l2_lat;
  wire [PROD_W-1:0]                  l2_sum;
  wire [PROD_W-1:0]                  l2_carry;

  genvar g;
  genvar i;

  // Level one, rows 0 to 26 in groups of nine
  for (g = 0; g < L1_GROUPS; g++) begin : g_l1
    assign l1_lat[g][0] = '0;
    for (i = 0; i < PROD_W; i++) begin : g_bit
      logic [CSA_GROUP-1:0] col;
      always_comb begin
        for (int k = 0; k < CSA_GROUP; k++) begin
          col[k] = rows[g*CSA_GROUP+k][i];
        end
      end
      csa_9to2 u_csa (
        .in    (col),
        .cin   (l1_lat[g][i]),
        .cout  (l1_lat[g][i+1]),
        .sum   (l1_sum[g][i]),
        .carry (l1_carry[g][i])
      );
    end
  end

  // Remaining six digit rows
  assign l1_lat6[0] = '0;
  for (i = 0; i < PROD_W; i++) begin : g_l1_six
    logic [5:0] col;
    always_comb begin
      for (int k = 0; k < 6; k++) begin
        col[k] = rows[L1_GROUPS*CSA_GROUP+k][i];
      end
    end
    csa_6to2 u_csa (
      .in    (col),
      .cin   (l1_lat6[i]),
      .cout  (l1_lat6[i+1]),
      .sum   (l1_sum[L1_GROUPS][i]),
      .carry (l1_carry[L1_GROUPS][i])
    );
  end

  for (g = 0; g <= L1_GROUPS; g++) begin : g_l2_in
    assign l2_in[2*g]   = l1_sum[g];
    assign l2_in[2*g+1] = {l1_carry[g][PROD_W-2:0], 1'b0};
  end
  assign l2_in[CSA_GROUP-1] = rows[NUM_PP-1];

  // Level two, eight vectors plus the last increment row
  assign l2_lat[0] = '0;
  for (i = 0; i < PROD_W; i++) begin : g_l2
    logic [CSA_GROUP-1:0] col;
    always_comb begin
      for (int k = 0; k < CSA_GROUP; k++) begin
        col[k] = l2_in[k][i];
      end
    end
    csa_9to2 u_csa (
      .in    (col),
      .cin   (l2_lat[i]),
      .cout  (l2_lat[i+1]),
      .sum   (l2_sum[i]),
      .carry (l2_carry[i])
    );
  end

  assign result = {l2_sum, l2_carry[PROD_W-2:0], 1'b0};  // sum then shifted carry

endmodule

`default_nettype wire

/* dv/tb_booth_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_booth_mul;
  import mul_pkg::*;

  localparam int NUM_RANDOM = 200;
  localparam int LATENCY    = 3;  // Drive edge to the falling edge that sees the result

  logic     clk;
  logic     rst_n;
  logic     enable;
  logic     negate;
  operand_t a;
  operand_t b;
  prod_t    product;
  logic     product_valid;

  // Stimulus table
  string    tab_name[$];
  operand_t tab_a[$];
  operand_t tab_b[$];
  logic     tab_neg[$];
  int       tab_gap[$];
  int       total_gap;
  bit       table_ready;

  // Scoreboard
  string    exp_name[$];
  prod_t    exp_val[$];
  int       exp_due[$];

  int       cycle;
  int       n_pass;
  int       n_fail;
  int       n_err;
  prod_t    last_product;
  bit       have_last;

  booth_mul_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .negate        (negate),
    .a             (a),
    .b             (b),
    .product       (product),
    .product_valid (product_valid)
  );

  always #10 clk = ~clk;

  // Unsigned product, negated modulo 2^64 on request
  function automatic prod_t expected_product(input operand_t x, input operand_t y,
                                             input logic neg);
    prod_t p;
    p = {32'b0, x} * {32'b0, y};
    if (neg) begin
      p = 64'd0 - p;
    end
    return p;
  endfunction

  task automatic add_entry(input string name, input operand_t x, input operand_t y,
                           input logic neg, input int gap);
    tab_name.push_back(name);
    tab_a.push_back(x);
    tab_b.push_back(y);
    tab_neg.push_back(neg);
    tab_gap.push_back(gap);
    total_gap += gap;
  endtask

  task automatic build_table();
    add_entry("zero_x",      32'h0000_0000, 32'h1234_5678, 1'b0, 0);
    add_entry("x_zero",      32'hDEAD_BEEF, 32'h0000_0000, 1'b0, 0);
    add_entry("one_x",       32'h0000_0001, 32'hCAFE_F00D, 1'b0, 0);
    add_entry("x_one",       32'h89AB_CDEF, 32'h0000_0001, 1'b0, 3);
    add_entry("max_max",     32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 0);
    add_entry("alt_5a",      32'h5555_5555, 32'hAAAA_AAAA, 1'b0, 0);
    add_entry("alt_a5",      32'hAAAA_AAAA, 32'h5555_5555, 1'b0, 5);
    add_entry("msb_msb",     32'h8000_0000, 32'h8000_0000, 1'b0, 1);
    add_entry("neg_zero_x",  32'h0000_0000, 32'h1234_5678, 1'b1, 0);
    add_entry("neg_one_x",   32'h0000_0001, 32'hCAFE_F00D, 1'b1, 0);
    add_entry("neg_max_max", 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1, 0);
    add_entry("neg_alt_5a",  32'h5555_5555, 32'hAAAA_AAAA, 1'b1, 0);
    add_entry("neg_alt_a5",  32'hAAAA_AAAA, 32'h5555_5555, 1'b1, 2);
    add_entry("neg_msb_msb", 32'h8000_0000, 32'h8000_0000, 1'b1, 4);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      // Mostly back to back with an occasional short pause
      add_entry($sformatf("rand_%0d", i), $urandom, $urandom, 1'($urandom_range(0, 1)),
                ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0);
    end
  endtask

  task automatic check_product(input string name, input prod_t expected, input prod_t actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      n_fail++;
    end else begin
      $display("ok %s product %h", name, actual);
      n_pass++;
    end
  endtask

  task automatic check_hold(input prod_t expected, input prod_t actual);
    if (actual !== expected) begin
      $display("mismatch hold cycle %0d expected %h actual %h", cycle, expected, actual);
      n_err++;
    end
  endtask

  task automatic check_valid_count(input logic valid, input bit expected, input string name);
    if ($isunknown(valid)) begin
      $display("product_valid is unknown at cycle %0d", cycle);
      n_err++;
    end else if (valid && !expected) begin
      $display("product_valid pulsed at cycle %0d with no request due", cycle);
      n_err++;
    end else if (!valid && expected) begin
      $display("no product_valid at cycle %0d for %s", cycle, name);
      n_fail++;
    end
  endtask

  // Sample outputs on the falling edge, before new inputs go out
  task automatic tick();
    bit    due_now;
    string nm;
    prod_t ev;
    @(negedge clk);
    cycle++;
    due_now = (exp_due.size() > 0) && (exp_due[0] == cycle);
    nm = due_now ? exp_name[0] : "";
    check_valid_count(product_valid, due_now, nm);
    if (due_now) begin
      ev = exp_val.pop_front();
      void'(exp_name.pop_front());
      void'(exp_due.pop_front());
      if (product_valid === 1'b1) begin
        check_product(nm, ev, product);
      end
    end else if (product_valid !== 1'b1 && have_last) begin
      check_hold(last_product, product);
    end
    if (product_valid === 1'b1) begin
      last_product = product;
      have_last    = 1'b1;
    end
  endtask

  // Operands change freely while enable is low
  task automatic drive_idle();
    enable = 1'b0;
    negate = 1'($urandom_range(0, 1));
    a      = $urandom;
    b      = $urandom;
  endtask

  initial begin : main
    void'($urandom(21559));
    clk          = 1'b0;
    rst_n        = 1'b0;
    enable       = 1'b0;
    negate       = 1'b0;
    a            = '0;
    b            = '0;
    total_gap    = 0;
    cycle        = 0;
    n_pass       = 0;
    n_fail       = 0;
    n_err        = 0;
    have_last    = 1'b0;
    last_product = '0;
    build_table();
    table_ready = 1'b1;

    repeat (2) tick();
    rst_n = 1'b1;
    repeat (2) begin
      tick();
      drive_idle();
    end

    for (int i = 0; i < tab_name.size(); i++) begin
      tick();
      enable = 1'b1;
      negate = tab_neg[i];
      a      = tab_a[i];
      b      = tab_b[i];
      exp_name.push_back(tab_name[i]);
      exp_val.push_back(expected_product(tab_a[i], tab_b[i], tab_neg[i]));
      exp_due.push_back(cycle + LATENCY);
      repeat (tab_gap[i]) begin
        tick();
        drive_idle();
      end
    end

    // Drain the pipeline
    while (exp_due.size() > 0) begin
      tick();
      drive_idle();
    end

    $display("tests: %0d ok, %0d bad, %0d other errors", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(tab_name.size() + total_gap + 10) * 20;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/booth_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_mul_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic              negate,
  input  mul_pkg::operand_t a,
  input  mul_pkg::operand_t b,
  output mul_pkg::prod_t    product,
  output logic              product_valid
);
  import mul_pkg::*;

  mul_req_t   req_in;
  mul_req_t   req_q;
  logic       req_valid;
  pp_array_t  rows;
  sum_carry_t sc_d;
  sum_carry_t sc_q;
  logic       sc_valid;

  assign req_in = '{negate: negate, a: a, b: b};

  // Stage 1
  pipe_reg #(.payload_t(mul_req_t)) u_in_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (enable),
    .d         (req_in),
    .q         (req_q),
    .valid_out (req_valid)
  );

  booth_pp_gen u_pp_gen (
    .req  (req_q),
    .rows (rows)
  );

  wallace_tree u_tree (
    .rows   (rows),
    .result (sc_d)
  );

  // Stage 2
  pipe_reg #(.payload_t(sum_carry_t)) u_mid_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (req_valid),
    .d         (sc_d),
    .q         (sc_q),
    .valid_out (sc_valid)
  );

  // Stage 3
  product_stage u_product (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_in      (sc_valid),
    .sc            (sc_q),
    .product       (product),
    .product_valid (product_valid)
  );

  // Every accepted request comes out three cycles later, and nothing else does
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> ##3 product_valid);
  a_no_phantom: assert property (@(posedge clk) disable iff (!rst_n)
    product_valid |-> $past(enable, 3));

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t d,
  output payload_t q,
  output logic     valid_out
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      q <= d;  // Holds otherwise
    end
  end

  // The strobe chain upstream must stay clean once out of reset
  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(valid_out));

endmodule

`default_nettype wire

/* rtl/product_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module product_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_in,
  input  mul_pkg::sum_carry_t sc,
  output mul_pkg::prod_t      product,
  output logic                product_valid
);
  import mul_pkg::*;

  prod_t hs;
  prod_t hc;
  prod_t total;

  // Last carry-save layer with the third input tied low
  always_comb begin
    for (int i = 0; i < PROD_W; i++) begin
      {hc[i], hs[i]} = full_add(sc.sum[i], sc.carry[i], 1'b0);
    end
  end

  assign total = hs + {hc[PROD_W-2:0], 1'b0};  // Wraps mod 2^64

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      product <= total;
    end
  end

  // A flagged product must come from fully defined operands through the whole tree
  a_product_known: assert property (@(posedge clk) disable iff (!rst_n)
    product_valid |-> !$isunknown(product));

endmodule

`default_nettype wire
